/* flist.f */
+incdir+include
rtl/vic_pkg.sv
rtl/vic_if.sv
rtl/vicRegFile.sv
rtl/vicRaster.sv
rtl/vicIrqCtrl.sv
rtl/vicVideoTiming.sv
rtl/vicTop.sv
sim/vicChecker.sv
sim/tb_vicTop.sv

/* sim/tb_vicTop.sv */
// testbench top: clock, reset, bus tasks, reference model, test sequence, watchdog, DUT
`include "vic_cfg.svh"

module tb_vicTop;
	localparam int K_DAT = 0, K_IRQ = 1, K_PER = 2, K_LOW = 3, K_HIGH = 4, K_YMAX = 5;
	localparam int K_VPER = 6, K_VLOW = 7, K_BLANK = 8, K_BORDER = 9;
	localparam int LINE_R8 = (int'(`VIC_XMAX_6567R8) + 1) * `VIC_DOT_DIV;
	localparam int FRAME_R8 = (int'(`VIC_YMAX_6567R8) + 1) * LINE_R8;
	localparam int LINE_6569 = (int'(`VIC_XMAX_6569) + 1) * `VIC_DOT_DIV;
	localparam int FRAME_6569 = (int'(`VIC_YMAX_6569) + 1) * LINE_6569;
	localparam int LINE_WAIT = 4 * LINE_R8;         // raster hit is two lines ahead
	localparam int WATCHDOG_CYC = 5 * FRAME_6569;   // about five frames

	logic        clk28, rst, csN, rw, lpN;
	logic [7:0]  adr, datIn, datOut;
	logic [1:0]  chip;
	logic        irq, hSync, vSync, blank, border;
	logic        reqValid;
	logic [3:0]  reqKind;
	logic [15:0] reqExp, reqAlt, reqAct;
	int          perCnt, chkCnt, errCnt;
	int          tbErr;    // timeouts seen by the sequence
	int          errMark;  // error total at start of test
	integer      seed;

	// shadow of written state
	logic [8:0]  shCmp;
	logic [3:0]  shEn;
	logic [7:0]  shSel;
	logic [11:0] shHTotal;
	logic        shPol, shVPol, shRasterFlag, shLpFlag;
	logic [1:0]  shChip;

	vicTop u_vicTop (
		.clk28(clk28), .rst(rst), .csN_i(csN), .rw_i(rw), .adr_i(adr), .dat_i(datIn),
		.dat_o(datOut), .chip_i(chip), .lpN_i(lpN), .irq_o(irq), .hSync_o(hSync),
		.vSync_o(vSync), .blank_o(blank), .border_o(border)
	);

	vicChecker u_checker (
		.clk28(clk28), .dat_i(datOut), .irq_i(irq), .hSync_i(hSync),
		.vSync_i(vSync), .blank_i(blank), .border_i(border),
		.reqValid_i(reqValid), .reqKind_i(reqKind), .reqExp_i(reqExp), .reqAlt_i(reqAlt),
		.reqAct_i(reqAct), .perCnt_o(perCnt), .chkCnt_o(chkCnt), .errCnt_o(errCnt)
	);

	initial begin
		clk28 = 1'b0;
		forever #4 clk28 = ~clk28;
	end

	// --------------------
	// reference model
	function automatic logic [15:0] refModel(input int kind, input logic [7:0] a,
		input logic [8:0] y);
		logic        pending;
		logic [15:0] width;
		logic [15:0] vWidth;
		logic [15:0] total;
		pending = (shRasterFlag & shEn[0]) | (shLpFlag & shEn[3]);
		width = `VIC_H_SYNC_OFF - `VIC_H_SYNC_ON;  // active part of a line
		vWidth = `VIC_V_SYNC_OFF - `VIC_V_SYNC_ON;  // sync lines per frame
		total = {4'h0, shHTotal};
		case (kind)
		K_IRQ:  return {15'd0, pending};
		K_PER:  return total;
		K_LOW:  return shPol ? width : total - width;
		K_HIGH: return shPol ? total - width : width;
		K_YMAX: return (shChip == `VIC_CHIP_6569) ? 16'(`VIC_YMAX_6569) : 16'(`VIC_YMAX_6567R8);
		K_VPER: return {4'h0, `VIC_V_TOTAL};
		K_VLOW: return shVPol ? vWidth : {4'h0, `VIC_V_TOTAL} - vWidth;
		K_BLANK:  return `VIC_H_BLANK_ON - `VIC_H_BLANK_OFF;    // visible part of a line
		K_BORDER: return `VIC_H_BORDER_ON - `VIC_H_BORDER_OFF;  // inner display window
		default: begin
			case (a)
			`VIC_ADR_RASTER_CTRL: return {8'h00, y[8], 7'h7F};
			`VIC_ADR_RASTER:      return {8'h00, y[7:0]};
			`VIC_ADR_LPY:         return {8'h00, y[8:1]};
			`VIC_ADR_IRQ_STAT:    return {8'h00, pending, 3'b111, shLpFlag, 2'b00, shRasterFlag};
			`VIC_ADR_IRQ_EN:      return {8'h00, 4'hF, shEn};
			`VIC_ADR_TREG_SEL:    return {8'h00, shSel};
			default:              return 16'h00FF;
			endcase
		end
		endcase
	endfunction

	// --------------------
	// bus and pin tasks
	task automatic resetDut(input logic [1:0] c);
		@(posedge clk28);
		#1;
		rst = 1'b1;
		chip = c;
		csN = 1'b1;
		rw = 1'b1;
		lpN = 1'b1;
		repeat (8) @(posedge clk28);
		#1;
		rst = 1'b0;
		shCmp = '0;
		shEn = '0;
		shSel = '0;
		shHTotal = `VIC_H_TOTAL;
		shPol = `VIC_SYNC_POL;
		shVPol = `VIC_SYNC_POL;
		shRasterFlag = 1'b0;
		shLpFlag = 1'b0;
		shChip = c;
	endtask

	task automatic writeReg(input logic [7:0] a, input logic [7:0] d);
		@(posedge clk28);
		#1;
		csN = 1'b0;
		rw = 1'b0;
		adr = a;
		datIn = d;
		@(posedge clk28);
		#1;
		csN = 1'b1;
		rw = 1'b1;
		case (a)
		`VIC_ADR_RASTER_CTRL: shCmp[8] = d[7];
		`VIC_ADR_RASTER:      shCmp[7:0] = d;
		`VIC_ADR_IRQ_EN:      shEn = d[3:0];
		`VIC_ADR_TREG_SEL:    shSel = d;
		`VIC_ADR_IRQ_STAT: begin
			shRasterFlag = shRasterFlag & ~d[0];  // write one to clear
			shLpFlag = shLpFlag & ~d[3];
		end
		`VIC_ADR_TREG_DAT: begin
			if (shSel == 8'h0C)
				shHTotal[7:0] = d;
			else if (shSel == 8'h0D)
				shHTotal[11:8] = d[3:0];
			else if (shSel == 8'h0F) begin
				shPol = d[0];
				shVPol = d[1];
			end
		end
		default: ;
		endcase
	endtask

	task automatic readReg(input logic [7:0] a, output logic [7:0] v);
		@(posedge clk28);
		#1;
		csN = 1'b0;
		rw = 1'b1;
		adr = a;
		@(posedge clk28);
		#1;
		csN = 1'b1;
		v = datOut;  // held until next read
	endtask

	task automatic checkValue(input int kind, input logic [15:0] e, input logic [15:0] alt,
		input logic [15:0] act);
		@(posedge clk28);
		#1;
		reqValid = 1'b1;
		reqKind = 4'(kind);
		reqExp = e;
		reqAlt = alt;
		reqAct = act;
		@(posedge clk28);
		#1;
		reqValid = 1'b0;
	endtask

	task automatic checkRead(input logic [7:0] a, input logic [8:0] y, input logic [8:0] yAlt);
		logic [7:0] v;
		readReg(a, v);
		checkValue(K_DAT, refModel(K_DAT, a, y), refModel(K_DAT, a, yAlt), 16'h0);
	endtask

	task automatic readRasterY(output logic [8:0] y);
		logic [7:0] hi1, lo, hi2;
		do begin
			readReg(`VIC_ADR_RASTER_CTRL, hi1);
			readReg(`VIC_ADR_RASTER, lo);
			readReg(`VIC_ADR_RASTER_CTRL, hi2);
		end while (hi1[7] != hi2[7]);  // bit 8 moved, read again
		y = {hi1[7], lo};
	endtask

	task automatic scanFrame(input int cycles, output logic [8:0] yTop);
		logic [8:0] y;
		longint     t0;
		yTop = '0;
		t0 = $time;
		while ($time - t0 < longint'(cycles) * 8) begin
			readRasterY(y);
			if (y > yTop)
				yTop = y;
		end
	endtask

	task automatic waitPeriods(input int n);
		int start;
		int cyc;
		start = perCnt;
		cyc = 0;
		while (perCnt < start + n && cyc < 8 * 4096) begin
			@(posedge clk28);
			#1;
			cyc++;
		end
		if (perCnt < start + n) begin
			tbErr++;
			$display("hSync_o stopped toggling, %0d of %0d periods seen", perCnt - start, n);
		end
	endtask

	task automatic waitIrq(input int limit);
		int n;
		n = 0;
		while (!irq && n < limit) begin
			@(posedge clk28);
			#1;
			n++;
		end
		if (!irq) begin
			tbErr++;
			$display("irq_o did not rise within %0d cycles", limit);
		end
	endtask

	task automatic pollStatus(input int bitIdx, input int limit);
		logic [7:0] v;
		int         n;
		v = 8'h00;
		n = 0;
		while (!v[bitIdx] && n < limit) begin
			readReg(`VIC_ADR_IRQ_STAT, v);
			n++;
		end
		if (!v[bitIdx]) begin
			tbErr++;
			$display("status bit %0d never set after %0d reads", bitIdx, limit);
		end
	endtask

	task automatic pulsePen();
		@(posedge clk28);
		#1;
		lpN = 1'b0;
		repeat (2) @(posedge clk28);
		#1;
		lpN = 1'b1;
	endtask

	task automatic endTest(input string name);
		int now;
		now = errCnt + tbErr;
		$display("test %s %s", name, (now == errMark) ? "ok" : "with errors");
		errMark = now;
	endtask

	// compare value two lines ahead, wrapped at the R8 frame end
	function automatic logic [8:0] aheadOf(input logic [8:0] y);
		return (y + 9'd2 > `VIC_YMAX_6567R8) ? y + 9'd2 - `VIC_YMAX_6567R8 - 9'd1 : y + 9'd2;
	endfunction

	task automatic setCompare(input logic [8:0] c);
		writeReg(`VIC_ADR_RASTER, c[7:0]);
		writeReg(`VIC_ADR_RASTER_CTRL, {c[8], 7'h00});
		writeReg(`VIC_ADR_IRQ_STAT, 8'hFF);  // drop hits from the half-written value
	endtask

	// --------------------
	// test sequence
	initial begin
		logic [7:0] a, v, lpx0;
		logic [8:0] y, cmp, ySeen;
		rst = 1'b1;
		csN = 1'b1;
		rw = 1'b1;
		adr = '0;
		datIn = '0;
		chip = `VIC_CHIP_6567R8;
		lpN = 1'b1;
		reqValid = 1'b0;
		reqKind = '0;
		reqExp = '0;
		reqAlt = '0;
		reqAct = '0;
		tbErr = 0;
		errMark = 0;
		seed = 32'h4291_2fb8;
		resetDut(`VIC_CHIP_6567R8);

		// register read-back
		repeat (8) begin
			writeReg(`VIC_ADR_RASTER, 8'($random(seed)));
			writeReg(`VIC_ADR_RASTER_CTRL, 8'($random(seed)));
			writeReg(`VIC_ADR_IRQ_EN, 8'($random(seed)));
			writeReg(`VIC_ADR_TREG_SEL, 8'($random(seed)));
			checkRead(`VIC_ADR_IRQ_EN, 9'd0, 9'd0);
			checkRead(`VIC_ADR_TREG_SEL, 9'd0, 9'd0);
		end
		checkRead(8'h00, 9'd0, 9'd0);
		checkRead(8'hFF, 9'd0, 9'd0);
		repeat (16) begin
			a = 8'($random(seed));
			case (a)
			`VIC_ADR_RASTER_CTRL, `VIC_ADR_RASTER, `VIC_ADR_LPX, `VIC_ADR_LPY,
			`VIC_ADR_IRQ_STAT, `VIC_ADR_IRQ_EN, `VIC_ADR_TREG_SEL, `VIC_ADR_TREG_DAT: ;
			default: checkRead(a, 9'd0, 9'd0);
			endcase
		end
		endTest("register read-back");

		// default timing, second full period is clean
		waitPeriods(2);
		checkValue(K_PER, refModel(K_PER, 0, 0), refModel(K_PER, 0, 0), 16'h0);
		checkValue(K_LOW, refModel(K_LOW, 0, 0), refModel(K_LOW, 0, 0), 16'h0);
		endTest("default timing");

		// hTotal = 800 through the window, then both polarities to 0
		writeReg(`VIC_ADR_TREG_SEL, 8'h0C);
		writeReg(`VIC_ADR_TREG_DAT, 8'h20);
		writeReg(`VIC_ADR_TREG_SEL, 8'h0D);
		writeReg(`VIC_ADR_TREG_DAT, 8'h03);
		waitPeriods(3);
		checkValue(K_PER, refModel(K_PER, 0, 0), refModel(K_PER, 0, 0), 16'h0);
		writeReg(`VIC_ADR_TREG_SEL, 8'h0F);
		writeReg(`VIC_ADR_TREG_DAT, 8'h00);
		waitPeriods(3);
		checkValue(K_HIGH, refModel(K_HIGH, 0, 0), refModel(K_HIGH, 0, 0), 16'h0);
		checkValue(K_LOW, refModel(K_LOW, 0, 0), refModel(K_LOW, 0, 0), 16'h0);
		endTest("indirect timing");

		// raster interrupt, enabled
		writeReg(`VIC_ADR_IRQ_EN, 8'h00);
		readRasterY(y);
		cmp = aheadOf(y);
		setCompare(cmp);
		writeReg(`VIC_ADR_IRQ_EN, 8'h01);
		waitIrq(LINE_WAIT);
		shRasterFlag = 1'b1;
		checkRead(`VIC_ADR_RASTER_CTRL, cmp, cmp);
		checkRead(`VIC_ADR_RASTER, cmp, cmp);
		checkRead(`VIC_ADR_IRQ_STAT, cmp, cmp);
		writeReg(`VIC_ADR_IRQ_STAT, 8'h01);
		checkValue(K_IRQ, refModel(K_IRQ, 0, 0), refModel(K_IRQ, 0, 0), 16'h0);
		// enable clear, flag only
		writeReg(`VIC_ADR_IRQ_EN, 8'h00);
		readRasterY(y);
		setCompare(aheadOf(y));
		pollStatus(0, LINE_WAIT / 2);
		shRasterFlag = 1'b1;
		checkValue(K_IRQ, refModel(K_IRQ, 0, 0), refModel(K_IRQ, 0, 0), 16'h0);
		setCompare(9'h1FF);  // never reached
		endTest("raster interrupt");

		// light pen, stay clear of the re-arm line
		do begin
			readRasterY(y);
		end while (y >= `VIC_YMAX_6567R8 - 9'd1);
		pulsePen();
		shLpFlag = 1'b1;
		checkRead(`VIC_ADR_LPY, y, y + 9'd1);
		checkRead(`VIC_ADR_IRQ_STAT, y, y);
		readReg(`VIC_ADR_LPX, lpx0);
		pulsePen();  // same frame, ignored
		readReg(`VIC_ADR_LPX, v);
		checkValue(K_DAT, {8'h00, lpx0}, {8'h00, lpx0}, 16'h0);
		checkRead(`VIC_ADR_LPY, y, y + 9'd1);
		endTest("light pen");

		// chip limits over one frame plus a line
		scanFrame(FRAME_R8 + LINE_R8, ySeen);
		checkValue(K_YMAX, refModel(K_YMAX, 0, 0), refModel(K_YMAX, 0, 0), {7'h00, ySeen});
		resetDut(`VIC_CHIP_6569);
		scanFrame(FRAME_6569 + LINE_6569, ySeen);
		checkValue(K_YMAX, refModel(K_YMAX, 0, 0), refModel(K_YMAX, 0, 0), {7'h00, ySeen});
		endTest("chip limits");

		// frame timing back at reset limits, the 6569 scan outlasts a full video frame
		checkValue(K_VPER, refModel(K_VPER, 0, 0), refModel(K_VPER, 0, 0), 16'h0);
		checkValue(K_VLOW, refModel(K_VLOW, 0, 0), refModel(K_VLOW, 0, 0), 16'h0);
		checkValue(K_BLANK, refModel(K_BLANK, 0, 0), refModel(K_BLANK, 0, 0), 16'h0);
		checkValue(K_BORDER, refModel(K_BORDER, 0, 0), refModel(K_BORDER, 0, 0), 16'h0);
		endTest("frame timing");

		$display("checks %0d, errors %0d", chkCnt, errCnt + tbErr);
		if (errCnt + tbErr == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYC) @(posedge clk28);
		$display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYC);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

/* sim/vicChecker.sv */
// testbench checker: hSync, vSync, blank and border measurement, request compare, counts
module vicChecker (
	input  logic        clk28,
	input  logic [7:0]  dat_i,       // DUT read data
	input  logic        irq_i,
	input  logic        hSync_i,
	input  logic        vSync_i,
	input  logic        blank_i,
	input  logic        border_i,
	input  logic        reqValid_i,  // one cycle per check
	input  logic [3:0]  reqKind_i,
	input  logic [15:0] reqExp_i,
	input  logic [15:0] reqAlt_i,    // second accepted value
	input  logic [15:0] reqAct_i,    // value seen by the testbench, rasterY max only
	output int          perCnt_o,
	output int          chkCnt_o,
	output int          errCnt_o
);
	logic        hsPrev, vsPrev;
	int          runLen;     // samples since last edge
	int          sinceFall;  // samples since last falling edge
	int          vsMark;     // hSync periods at last vSync fall
	int          blankRun, borderRun;  // low samples so far
	logic [15:0] period, lowW, highW;
	logic [15:0] vPeriod, vLowW;  // in lines
	logic [15:0] blankLowW, borderLowW;

	initial begin
		hsPrev = 1'b1;
		vsPrev = 1'b1;
		runLen = 0;
		sinceFall = 0;
		vsMark = 0;
		blankRun = 0;
		borderRun = 0;
		period = '0;
		lowW = '0;
		highW = '0;
		vPeriod = '0;
		vLowW = '0;
		blankLowW = '0;
		borderLowW = '0;
		perCnt_o = 0;
		chkCnt_o = 0;
		errCnt_o = 0;
	end

	// --------------------
	// hSync measurement
	always @(posedge clk28) begin
		hsPrev <= hSync_i;
		if (hSync_i == hsPrev) begin
			runLen <= runLen + 1;
			sinceFall <= sinceFall + 1;
		end else if (hsPrev) begin  // falling edge
			highW <= 16'(runLen);
			period <= 16'(sinceFall);
			perCnt_o <= perCnt_o + 1;
			runLen <= 1;
			sinceFall <= 1;
		end else begin              // rising edge
			lowW <= 16'(runLen);
			runLen <= 1;
			sinceFall <= sinceFall + 1;
		end
	end

	// --------------------
	// vSync in lines, blank and border low runs in cycles
	always @(posedge clk28) begin
		vsPrev <= vSync_i;
		if (vsPrev && !vSync_i) begin  // falling edge
			vPeriod <= 16'(perCnt_o - vsMark);
			vsMark <= perCnt_o;
		end else if (!vsPrev && vSync_i)
			vLowW <= 16'(perCnt_o - vsMark);
		if (!blank_i)
			blankRun <= blankRun + 1;
		else if (blankRun != 0) begin
			blankLowW <= 16'(blankRun);
			blankRun <= 0;
		end
		if (!border_i)
			borderRun <= borderRun + 1;
		else if (borderRun != 0) begin
			borderLowW <= 16'(borderRun);
			borderRun <= 0;
		end
	end

	// --------------------
	// compare on request
	always @(posedge clk28) begin
		logic [15:0] act;
		string       name;
		if (reqValid_i) begin
			case (reqKind_i)
			4'd0: begin
				act = {8'h00, dat_i};
				name = "dat_o";
			end
			4'd1: begin
				act = {15'd0, irq_i};
				name = "irq_o";
			end
			4'd2: begin
				act = period;
				name = "hSync_o period";
			end
			4'd3: begin
				act = lowW;
				name = "hSync_o low time";
			end
			4'd4: begin
				act = highW;
				name = "hSync_o high time";
			end
			4'd6: begin
				act = vPeriod;
				name = "vSync_o period in lines";
			end
			4'd7: begin
				act = vLowW;
				name = "vSync_o low time in lines";
			end
			4'd8: begin
				act = blankLowW;
				name = "blank_o low time";
			end
			4'd9: begin
				act = borderLowW;
				name = "border_o low time";
			end
			default: begin
				act = reqAct_i;
				name = "rasterY max";
			end
			endcase
			chkCnt_o <= chkCnt_o + 1;
			if (act != reqExp_i && act != reqAlt_i) begin
				errCnt_o <= errCnt_o + 1;
				$display("Mismatch %s: expected 0x%0h, got 0x%0h at time %0t",
					name, reqExp_i, act, $time);
			end
		end
	end

endmodule

/* rtl/vicTop.sv */
// top level with plain ports, interface instances and block wiring
module vicTop (
	input  logic       clk28,
	input  logic       rst,
	input  logic       csN_i,
	input  logic       rw_i,
	input  logic [7:0] adr_i,
	input  logic [7:0] dat_i,
	output logic [7:0] dat_o,
	input  logic [1:0] chip_i,
	input  logic       lpN_i,
	output logic       irq_o,
	output logic       hSync_o,
	output logic       vSync_o,
	output logic       blank_o,
	output logic       border_o
);
	timingCfgIf tcfg ();
	irqLinkIf   link ();

	// cpu side registers
	vicRegFile u_regFile (
		.clk28 (clk28),
		.rst   (rst),
		.csN_i (csN_i),
		.rw_i  (rw_i),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.dat_o (dat_o),
		.tcfg  (tcfg.regs),
		.link  (link.regs)
	);

	vicRaster u_raster (
		.clk28  (clk28),
		.rst    (rst),
		.chip_i (chip_i),
		.lpN_i  (lpN_i),
		.link   (link.raster)
	);

	vicIrqCtrl u_irqCtrl (
		.clk28 (clk28),
		.rst   (rst),
		.irq_o (irq_o),
		.link  (link.irq)
	);

	// --------------------
	// monitor timing
	vicVideoTiming u_videoTiming (
		.clk28    (clk28),
		.rst      (rst),
		.hSync_o  (hSync_o),
		.vSync_o  (vSync_o),
		.blank_o  (blank_o),
		.border_o (border_o),
		.tcfg     (tcfg.timing)
	);

endmodule

/* rtl/vicVideoTiming.sv */
// programmable h/v counters with registered sync, blank and border
module vicVideoTiming (
	input  logic       clk28,
	input  logic       rst,
	output logic       hSync_o,
	output logic       vSync_o,
	output logic       blank_o,
	output logic       border_o,
	timingCfgIf.timing tcfg
);
	logic [11:0] hCtr, vCtr;
	logic        eol, eof;
	logic        hSyncAct, vSyncAct;
	logic        hBlank, vBlank, hBorder, vBorder;

	assign eol = hCtr == tcfg.hTotal;
	assign eof = eol && vCtr == tcfg.vTotal;

	// counters run 1..total
	always_ff @(posedge clk28) begin
		if (rst) begin
			hCtr <= 12'd1;
			vCtr <= 12'd1;
		end else begin
			hCtr <= eol ? 12'd1 : hCtr + 12'd1;
			if (eol)
				vCtr <= eof ? 12'd1 : vCtr + 12'd1;
		end
	end

	// --------------------
	// window compares
	assign hSyncAct = hCtr >= tcfg.hSyncOn && hCtr < tcfg.hSyncOff;
	assign vSyncAct = vCtr >= tcfg.vSyncOn && vCtr < tcfg.vSyncOff;
	assign hBlank = hCtr >= tcfg.hBlankOn || hCtr < tcfg.hBlankOff;
	assign vBlank = vCtr >= tcfg.vBlankOn || vCtr < tcfg.vBlankOff;
	assign hBorder = hCtr >= tcfg.hBorderOn || hCtr < tcfg.hBorderOff;
	assign vBorder = vCtr >= tcfg.vBorderOn || vCtr < tcfg.vBorderOff;

	always_ff @(posedge clk28) begin
		if (rst) begin
			hSync_o <= tcfg.hSyncPol;  // idle level
			vSync_o <= tcfg.vSyncPol;
			blank_o <= 1'b1;
			border_o <= 1'b1;
		end else begin
			hSync_o <= hSyncAct ^ tcfg.hSyncPol;
			vSync_o <= vSyncAct ^ tcfg.vSyncPol;
			blank_o <= hBlank | vBlank;
			border_o <= hBorder | vBorder;
		end
	end

endmodule

/* rtl/vicIrqCtrl.sv */
// raster compare, interrupt flags, enables, write-one clear and irq level
module vicIrqCtrl import vic_pkg::*; (
	input  logic clk28,
	input  logic rst,
	output logic irq_o,
	irqLinkIf.irq link
);
	logic rasterFlag, lpFlag;
	logic rasterDone;  // one raster hit per line
	logic rasterHit;

	assign rasterHit = (!rasterDone || link.lineStart) && link.rasterY == link.rasterCmp;

	// --------------------
	// flags, set wins over clear
	always_ff @(posedge clk28) begin
		if (rst) begin
			rasterFlag <= 1'b0;
			lpFlag <= 1'b0;
			rasterDone <= 1'b0;
		end else begin
			if (link.lineStart)
				rasterDone <= 1'b0;
			if (link.irqClr.f.raster)
				rasterFlag <= 1'b0;
			if (link.irqClr.f.lightPen)
				lpFlag <= 1'b0;
			if (rasterHit) begin
				rasterDone <= 1'b1;
				rasterFlag <= 1'b1;
			end
			if (link.lpHit)
				lpFlag <= 1'b1;
		end
	end

	// level out, sprite sources never fire
	assign irq_o = (rasterFlag & link.irqEn.f.raster) | (lpFlag & link.irqEn.f.lightPen);

	always_comb begin
		link.irqStat.f.pending = irq_o;
		link.irqStat.f.unused = 3'b111;  // read as ones
		link.irqStat.f.lightPen = lpFlag;
		link.irqStat.f.sprSpr = 1'b0;
		link.irqStat.f.sprBg = 1'b0;
		link.irqStat.f.raster = rasterFlag;
	end

endmodule

/* rtl/vicRaster.sv */
// dot enable, raster x/y counters and light pen latch
`include "vic_cfg.svh"

module vicRaster import vic_pkg::*; (
	input  logic       clk28,
	input  logic       rst,
	input  logic [1:0] chip_i,
	input  logic       lpN_i,
	irqLinkIf.raster   link
);
	localparam int DIV_W = $clog2(`VIC_DOT_DIV);

	logic [1:0]       chip;
	logic [DIV_W-1:0] dotCnt;
	logic             dotEn;
	logic [10:0]      rasterX, xMax;
	logic [8:0]       rasterY, yMax;
	logic             eol;
	logic             lpDone;  // one hit per frame

	// chip pins only looked at in reset
	always_ff @(posedge clk28)
		if (rst)
			chip <= chip_i;

	assign xMax = rasterXMaxFor(chip);
	assign yMax = rasterYMaxFor(chip);
	assign dotEn = dotCnt == DIV_W'(`VIC_DOT_DIV - 1);
	assign eol = dotEn && rasterX == xMax;

	// --------------------
	// raster counters
	always_ff @(posedge clk28) begin
		if (rst) begin
			dotCnt <= '0;
			rasterX <= '0;
			rasterY <= '0;
			link.lineStart <= 1'b0;
		end else begin
			dotCnt <= dotEn ? '0 : dotCnt + 1'b1;
			link.lineStart <= eol;  // lines up with x == 0
			if (eol) begin
				rasterX <= '0;
				rasterY <= (rasterY == yMax) ? 9'd0 : rasterY + 9'd1;
			end else if (dotEn)
				rasterX <= rasterX + 11'd1;
		end
	end

	// light pen, first low sample wins
	always_ff @(posedge clk28) begin
		if (rst) begin
			lpDone <= 1'b0;
			link.lpHit <= 1'b0;
		end else begin
			link.lpHit <= 1'b0;
			if (rasterY == yMax)
				lpDone <= 1'b0;  // re-arm on last line
			else if (!lpDone && !lpN_i) begin
				lpDone <= 1'b1;
				link.lpHit <= 1'b1;
			end
		end
	end

	// coordinates, no reset
	always_ff @(posedge clk28)
		if (!rst && rasterY != yMax && !lpDone && !lpN_i) begin
			link.lpx <= rasterX[8:1];
			link.lpy <= rasterY[8:1];
		end

	assign link.rasterX = rasterX;
	assign link.rasterY = rasterY;

endmodule

/* rtl/vicRegFile.sv */
// cpu bus decode, register storage, read-back mux and indirect timing registers
`include "vic_cfg.svh"

module vicRegFile import vic_pkg::*; (
	input  logic       clk28,
	input  logic       rst,
	input  logic       csN_i,
	input  logic       rw_i,
	input  logic [7:0] adr_i,
	input  logic [7:0] dat_i,
	output logic [7:0] dat_o,
	timingCfgIf.regs   tcfg,
	irqLinkIf.regs     link
);
	// slot order follows the index map, h limits then v limits
	localparam logic [11:0] LIM_DEF [14] = '{
		`VIC_H_SYNC_ON, `VIC_H_SYNC_OFF, `VIC_H_BLANK_OFF, `VIC_H_BORDER_OFF,
		`VIC_H_BORDER_ON, `VIC_H_BLANK_ON, `VIC_H_TOTAL,
		`VIC_V_SYNC_ON, `VIC_V_SYNC_OFF, `VIC_V_BLANK_OFF, `VIC_V_BORDER_OFF,
		`VIC_V_BORDER_ON, `VIC_V_BLANK_ON, `VIC_V_TOTAL
	};

	logic        wrEn, rdEn;
	logic [8:0]  rasterCmp;
	irqFlags_u   irqEn;
	logic [7:0]  tregSel;    // indirect index
	logic [11:0] lim [14];
	logic        hSyncPol, vSyncPol;
	logic [3:0]  slot;
	logic        slotOk;
	logic [7:0]  rdMux;

	assign wrEn = !csN_i && !rw_i;  // plain strobe
	assign rdEn = !csN_i && rw_i;

	// index 0x00-0x0D horizontal, 0x10-0x1D vertical
	always_comb begin
		slot = tregSel[4] ? 4'd7 + {1'b0, tregSel[3:1]} : {1'b0, tregSel[3:1]};
		slotOk = (tregSel[7:5] == 3'd0) && (tregSel[3:1] != 3'b111);  // 0x0E/0x1E/0x1F no-op
	end

	// --------------------
	// register writes
	always_ff @(posedge clk28) begin
		if (rst) begin
			rasterCmp <= '0;
			irqEn.raw <= '0;
			tregSel <= '0;
			hSyncPol <= `VIC_SYNC_POL;
			vSyncPol <= `VIC_SYNC_POL;
			for (int i = 0; i < 14; i++)
				lim[i] <= LIM_DEF[i];
		end else if (wrEn) begin
			case (adr_i)
			`VIC_ADR_RASTER_CTRL: rasterCmp[8] <= dat_i[7];  // other bits dropped
			`VIC_ADR_RASTER:      rasterCmp[7:0] <= dat_i;
			`VIC_ADR_IRQ_EN:      irqEn.raw <= {4'h0, dat_i[3:0]};
			`VIC_ADR_TREG_SEL:    tregSel <= dat_i;
			`VIC_ADR_TREG_DAT: begin
				if (tregSel == 8'h0F) begin
					hSyncPol <= dat_i[0];
					vSyncPol <= dat_i[1];
				end else if (slotOk) begin
					if (tregSel[0])
						lim[slot][11:8] <= dat_i[3:0];  // odd, high nibble
					else
						lim[slot][7:0] <= dat_i;
				end
			end
			default: ;
			endcase
		end
	end

	// clear mask straight off the bus
	always_comb
		link.irqClr.raw = (wrEn && adr_i == `VIC_ADR_IRQ_STAT) ? dat_i : 8'h00;

	// --------------------
	// read-back
	always_comb begin
		case (adr_i)
		`VIC_ADR_RASTER_CTRL: rdMux = {link.rasterY[8], 7'h7F};
		`VIC_ADR_RASTER:      rdMux = link.rasterY[7:0];
		`VIC_ADR_LPX:         rdMux = link.lpx;
		`VIC_ADR_LPY:         rdMux = link.lpy;
		`VIC_ADR_IRQ_STAT:    rdMux = link.irqStat.raw;
		`VIC_ADR_IRQ_EN:      rdMux = {4'hF, irqEn.raw[3:0]};
		`VIC_ADR_TREG_SEL:    rdMux = tregSel;
		default:              rdMux = 8'hFF;
		endcase
	end

	always_ff @(posedge clk28) begin
		if (rst)
			dat_o <= 8'hFF;
		else if (rdEn)
			dat_o <= rdMux;  // held until next read
	end

	assign link.rasterCmp = rasterCmp;
	assign link.irqEn = irqEn;

	assign tcfg.hSyncOn    = lim[0];
	assign tcfg.hSyncOff   = lim[1];
	assign tcfg.hBlankOff  = lim[2];
	assign tcfg.hBorderOff = lim[3];
	assign tcfg.hBorderOn  = lim[4];
	assign tcfg.hBlankOn   = lim[5];
	assign tcfg.hTotal     = lim[6];
	assign tcfg.vSyncOn    = lim[7];
	assign tcfg.vSyncOff   = lim[8];
	assign tcfg.vBlankOff  = lim[9];
	assign tcfg.vBorderOff = lim[10];
	assign tcfg.vBorderOn  = lim[11];
	assign tcfg.vBlankOn   = lim[12];
	assign tcfg.vTotal     = lim[13];
	assign tcfg.hSyncPol   = hSyncPol;
	assign tcfg.vSyncPol   = vSyncPol;

endmodule

/* rtl/vic_if.sv */
// timingCfgIf and irqLinkIf interfaces with their modports

// video timing limits, levels from the register file
interface timingCfgIf;
	logic [11:0] hSyncOn, hSyncOff, hBlankOff, hBorderOff, hBorderOn, hBlankOn, hTotal;
	logic [11:0] vSyncOn, vSyncOff, vBlankOff, vBorderOff, vBorderOn, vBlankOn, vTotal;
	logic        hSyncPol, vSyncPol;

	modport regs (
		output hSyncOn, hSyncOff, hBlankOff, hBorderOff, hBorderOn, hBlankOn, hTotal,
		output vSyncOn, vSyncOff, vBlankOff, vBorderOff, vBorderOn, vBlankOn, vTotal,
		output hSyncPol, vSyncPol
	);
	modport timing (
		input hSyncOn, hSyncOff, hBlankOff, hBorderOff, hBorderOn, hBlankOn, hTotal,
		input vSyncOn, vSyncOff, vBlankOff, vBorderOff, vBorderOn, vBlankOn, vTotal,
		input hSyncPol, vSyncPol
	);
endinterface

// raster position, light pen and irq traffic
interface irqLinkIf import vic_pkg::*; ();
	logic [8:0]  rasterCmp;
	irqFlags_u   irqEn;
	irqFlags_u   irqClr;     // single cycle, write to status reg
	irqFlags_u   irqStat;
	logic [8:0]  rasterY;
	logic [10:0] rasterX;
	logic        lineStart;  // pulse as x wraps
	logic [7:0]  lpx, lpy;
	logic        lpHit;      // pulse on latched pen

	modport regs (output rasterCmp, irqEn, irqClr, input irqStat, rasterY, lpx, lpy);
	modport irq (input rasterCmp, irqEn, irqClr, rasterY, lineStart, lpHit, output irqStat);
	modport raster (output rasterY, rasterX, lineStart, lpx, lpy, lpHit);
endinterface

/* rtl/vic_pkg.sv */
// interrupt flag union and chip raster limit lookup functions
`include "vic_cfg.svh"

package vic_pkg;

	// one byte seen as status, clear mask and enable mask
	typedef struct packed {
		logic       pending;  // mirror of irq line
		logic [2:0] unused;
		logic       lightPen;
		logic       sprSpr;   // no source, reads 0
		logic       sprBg;    // no source, reads 0
		logic       raster;
	} irqBits_t;

	typedef union packed {
		logic [7:0] raw;
		irqBits_t   f;
	} irqFlags_u;

	// last raster line for a chip code
	function automatic logic [8:0] rasterYMaxFor(input logic [1:0] chip);
		case (chip)
		`VIC_CHIP_6567R8:  return `VIC_YMAX_6567R8;
		`VIC_CHIP_6567OLD: return `VIC_YMAX_6567OLD;
		`VIC_CHIP_6569:    return `VIC_YMAX_6569;
		default:           return `VIC_YMAX_6572;
		endcase
	endfunction

	// last dot of a line
	function automatic logic [10:0] rasterXMaxFor(input logic [1:0] chip);
		case (chip)
		`VIC_CHIP_6567R8:  return `VIC_XMAX_6567R8;
		`VIC_CHIP_6567OLD: return `VIC_XMAX_6567OLD;
		`VIC_CHIP_6569:    return `VIC_XMAX_6569;
		default:           return `VIC_XMAX_6572;
		endcase
	endfunction

endpackage

/* include/vic_cfg.svh */
// register addresses, chip codes, raster limits, dot divider and default video timing
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

// register map, cpu side
`define VIC_ADR_RASTER_CTRL 8'h11  // bit 7 = raster bit 8
`define VIC_ADR_RASTER      8'h12
`define VIC_ADR_LPX         8'h13
`define VIC_ADR_LPY         8'h14
`define VIC_ADR_IRQ_STAT    8'h19
`define VIC_ADR_IRQ_EN      8'h1A
`define VIC_ADR_TREG_SEL    8'h30  // timing register index
`define VIC_ADR_TREG_DAT    8'h31  // timing register data

// chip type codes on chip_i
`define VIC_CHIP_6567R8  2'd0
`define VIC_CHIP_6567OLD 2'd1
`define VIC_CHIP_6569    2'd2
`define VIC_CHIP_6572    2'd3

// last raster line per chip
`define VIC_YMAX_6567R8  9'd262
`define VIC_YMAX_6567OLD 9'd261
`define VIC_YMAX_6569    9'd311
`define VIC_YMAX_6572    9'd311

// last dot of a line per chip
`define VIC_XMAX_6567R8  11'd519
`define VIC_XMAX_6567OLD 11'd511
`define VIC_XMAX_6569    11'd503
`define VIC_XMAX_6572    11'd503

`define VIC_DOT_DIV 4  // clk28 cycles per dot

// --------------------
// video timing reset values
`define VIC_H_SYNC_ON    12'd21
`define VIC_H_SYNC_OFF   12'd146
`define VIC_H_BLANK_OFF  12'd208
`define VIC_H_BORDER_OFF 12'd307
`define VIC_H_BORDER_ON  12'd947
`define VIC_H_BLANK_ON   12'd1040
`define VIC_H_TOTAL      12'd1040
`define VIC_V_SYNC_ON    12'd10
`define VIC_V_SYNC_OFF   12'd12
`define VIC_V_BLANK_OFF  12'd45
`define VIC_V_BORDER_OFF 12'd85
`define VIC_V_BORDER_ON  12'd485
`define VIC_V_BLANK_ON   12'd525
`define VIC_V_TOTAL      12'd525
`define VIC_SYNC_POL     1'b1  // both syncs idle high

`endif
